//--- build.f
rtl/fetch_pkg.sv
rtl/fetch_fifo.sv
rtl/fetch_bus_master.sv
rtl/insn_assembler.sv
rtl/fetch_unit.sv
test/wb_rom_model.sv
test/tb_fetch_unit.sv

//--- rtl/fetch_bus_master.sv
`timescale 1ns/100ps

module fetch_bus_master
  import fetch_pkg::*;
#(
  parameter int    REQ_MAX     = 4,
  parameter word_t START_ADDR  = 32'h0000_0000,
  parameter int    FIFO_AWIDTH = 4
)
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 pc_set_i,
  input  word_t                pc_in_i,
  input  logic                 halt_i,
  output logic                 cyc_o,
  output logic                 stb_o,
  output word_t                adr_o,
  input  logic                 stall_i,
  input  logic                 ack_i,
  input  logic [FIFO_AWIDTH:0] fifo_level_i,
  output logic                 push_o
);

  localparam int DEPTH = 1 << FIFO_AWIDTH;
  localparam logic [3:0] LAST_REQ = 4'(REQ_MAX - 1);

  bus_state_t state;
  bus_state_t state_nxt;
  word_t      adr_nxt;
  logic [3:0] req_cnt;
  logic [3:0] req_cnt_nxt;
  logic [3:0] ack_cnt;
  logic [3:0] ack_cnt_nxt;
  logic [3:0] in_flight;
  logic       halt_q;
  logic       halt_nxt;
  logic       room;

  assign in_flight = req_cnt - ack_cnt;
  assign room = (int'(fifo_level_i) + int'(in_flight) + REQ_MAX) <= DEPTH;

  assign cyc_o  = (state == BS_REQ) || (state == BS_WAIT) || (state == BS_DRAIN);
  assign stb_o  = (state == BS_REQ);
  assign push_o = ack_i && (state != BS_DRAIN);  // stale words are dropped

  always_comb
  begin
    state_nxt   = state;
    adr_nxt     = adr_o;
    halt_nxt    = halt_q;
    req_cnt_nxt = req_cnt;
    ack_cnt_nxt = ack_cnt + {3'b000, ack_i};
    case (state)
      BS_IDLE:
      begin
        req_cnt_nxt = '0;
        ack_cnt_nxt = '0;
        if (pc_set_i)
          adr_nxt = pc_in_i;
        else if (room)
          state_nxt = BS_REQ;
      end
      BS_REQ:
      begin
        if (!stall_i)
        begin
          adr_nxt     = adr_o + WORD_BYTES;
          req_cnt_nxt = req_cnt + 4'd1;
          if (req_cnt == LAST_REQ)
            state_nxt = BS_WAIT;
        end
        if (pc_set_i)
        begin
          adr_nxt   = pc_in_i;  // request accepted this cycle is still counted
          state_nxt = BS_DRAIN;
        end
      end
      BS_WAIT, BS_DRAIN:
      begin
        if (halt_i)
          halt_nxt = 1'b1;
        if (ack_cnt_nxt == req_cnt)
          state_nxt = halt_nxt ? BS_HALT : BS_IDLE;
        else if (pc_set_i)
          state_nxt = BS_DRAIN;
        if (pc_set_i)
          adr_nxt = pc_in_i;
      end
      default:
        state_nxt = BS_HALT;  // parked until reset
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state   <= BS_IDLE;
      adr_o   <= START_ADDR;
      req_cnt <= '0;
      ack_cnt <= '0;
      halt_q  <= 1'b0;
    end
    else
    begin
      state   <= state_nxt;
      adr_o   <= adr_nxt;
      req_cnt <= req_cnt_nxt;
      ack_cnt <= ack_cnt_nxt;
      halt_q  <= halt_nxt;
    end
  end

  // cyc covers every request and every ack still owed
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    (stb_o || (in_flight != 4'd0)) |-> cyc_o)
    else $error("fetch_bus_master: request or pending ack without cyc");

  a_ack_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |-> (in_flight != 4'd0))
    else $error("fetch_bus_master: ack with nothing in flight");

endmodule

//--- rtl/fetch_fifo.sv
`timescale 1ns/100ps

module fetch_fifo
  import fetch_pkg::*;
#(
  parameter int FIFO_AWIDTH = 4
)
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  logic                 push_i,
  input  word_t                data_i,
  input  logic                 pop_i,
  output word_t                data_o,
  output logic                 empty_o,
  output logic                 full_o,
  output logic [FIFO_AWIDTH:0] level_o
);

  localparam int DEPTH = 1 << FIFO_AWIDTH;

  word_t mem [DEPTH];

  // extra msb tells full from empty
  logic [FIFO_AWIDTH:0] wr_ptr;
  logic [FIFO_AWIDTH:0] rd_ptr;

  assign level_o = wr_ptr - rd_ptr;
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[FIFO_AWIDTH] != rd_ptr[FIFO_AWIDTH]) &&
                   (wr_ptr[FIFO_AWIDTH-1:0] == rd_ptr[FIFO_AWIDTH-1:0]);

  assign data_o = mem[rd_ptr[FIFO_AWIDTH-1:0]];  // head word visible before pop

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr <= '0;  // flush beats a push or pop on the same edge
      rd_ptr <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i && !flush_i)
      mem[wr_ptr[FIFO_AWIDTH-1:0]] <= data_i;
  end

  // bus master room check must keep this from ever firing
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !(push_i && full_o))
    else $error("fetch_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !(pop_i && empty_o))
    else $error("fetch_fifo: pop while empty");

endmodule

//--- rtl/fetch_pkg.sv
package fetch_pkg;

  // one bus data word or byte address
  typedef logic [31:0] word_t;

  // first fetched word in the low half, upper half zero for a short one
  typedef logic [63:0] insn_t;

  typedef enum logic [2:0]
  {
    BS_IDLE,
    BS_REQ,
    BS_WAIT,
    BS_DRAIN,
    BS_HALT
  } bus_state_t;

  typedef enum logic
  {
    AS_FIRST,
    AS_SECOND
  } asm_state_t;

  localparam int LONG_BIT = 0;            // set in a word that opens a long insn
  localparam word_t WORD_BYTES = 32'd4;   // address step per word

endpackage

//--- rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
  import fetch_pkg::*;
#(
  parameter int    REQ_MAX     = 4,
  parameter word_t START_ADDR  = 32'h0000_1000,
  parameter int    FIFO_AWIDTH = 4
)
(
  input  logic  clk_i,
  input  logic  rst_i,
  output logic  cyc_o,
  output logic  stb_o,
  output word_t adr_o,
  input  logic  bus_stall_i,  // slave stall, not decode stall
  input  logic  ack_i,
  input  word_t dat_i,
  input  logic  pc_set_i,
  input  word_t pc_in_i,
  input  logic  halt_i,
  input  logic  stall_i,
  output insn_t ir_o,
  output word_t pc_o,
  output logic  ir_valid_o
);

  logic                 fifo_push;
  logic                 fifo_pop;
  logic                 fifo_empty;
  logic [FIFO_AWIDTH:0] fifo_level;
  word_t                fifo_word;

  fetch_bus_master #(
    .REQ_MAX     (REQ_MAX),
    .START_ADDR  (START_ADDR),
    .FIFO_AWIDTH (FIFO_AWIDTH)
  ) i_bus_master (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pc_set_i     (pc_set_i),
    .pc_in_i      (pc_in_i),
    .halt_i       (halt_i),
    .cyc_o        (cyc_o),
    .stb_o        (stb_o),
    .adr_o        (adr_o),
    .stall_i      (bus_stall_i),
    .ack_i        (ack_i),
    .fifo_level_i (fifo_level),
    .push_o       (fifo_push)
  );

  fetch_fifo #(
    .FIFO_AWIDTH (FIFO_AWIDTH)
  ) i_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (pc_set_i),  // cleared on the redirect edge
    .push_i  (fifo_push),
    .data_i  (dat_i),
    .pop_i   (fifo_pop),
    .data_o  (fifo_word),
    .empty_o (fifo_empty),
    .full_o  (),
    .level_o (fifo_level)
  );

  insn_assembler #(
    .START_ADDR (START_ADDR)
  ) i_assembler (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .pc_set_i   (pc_set_i),
    .pc_in_i    (pc_in_i),
    .word_i     (fifo_word),
    .empty_i    (fifo_empty),
    .pop_o      (fifo_pop),
    .stall_i    (stall_i),
    .ir_o       (ir_o),
    .pc_o       (pc_o),
    .ir_valid_o (ir_valid_o)
  );

endmodule

//--- rtl/insn_assembler.sv
`timescale 1ns/100ps

module insn_assembler
  import fetch_pkg::*;
#(
  parameter word_t START_ADDR = 32'h0000_0000
)
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  pc_set_i,
  input  word_t pc_in_i,
  input  word_t word_i,
  input  logic  empty_i,
  output logic  pop_o,
  input  logic  stall_i,
  output insn_t ir_o,
  output word_t pc_o,
  output logic  ir_valid_o
);

  asm_state_t state;
  word_t      next_pc;   // address of the insn being built
  word_t      low_q;     // first half of a long insn
  logic       emit;
  logic       is_long;

  // output slot is consumed on every cycle decode is not stalled
  assign pop_o   = !empty_i && !stall_i && !pc_set_i;
  assign is_long = word_i[LONG_BIT];
  assign emit    = pop_o && ((state == AS_SECOND) || !is_long);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state      <= AS_FIRST;
      next_pc    <= START_ADDR;
      ir_valid_o <= 1'b0;
    end
    else if (pc_set_i)
    begin
      state      <= AS_FIRST;  // any half-built long insn is dropped
      next_pc    <= pc_in_i;
      ir_valid_o <= 1'b0;
    end
    else if (!stall_i)
    begin
      ir_valid_o <= emit;
      if (pop_o)
      begin
        case (state)
          AS_FIRST:
          begin
            if (is_long)
              state <= AS_SECOND;
            else
              next_pc <= next_pc + WORD_BYTES;
          end
          default:
          begin
            state   <= AS_FIRST;
            next_pc <= next_pc + (WORD_BYTES << 1);
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop_o && (state == AS_FIRST))
      low_q <= word_i;
    if (emit)
    begin
      if (state == AS_SECOND)
        ir_o <= {word_i, low_q};
      else
        ir_o <= {32'h0000_0000, word_i};
      pc_o <= next_pc;
    end
  end

  // a held instruction must not change under decode stall
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    (ir_valid_o && stall_i && !pc_set_i) |=>
      (ir_valid_o && $stable(ir_o) && $stable(pc_o)))
    else $error("insn_assembler: output changed while stalled");

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_fetch_unit -o sim_fetch > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_fetch > sim.log 2>&1
cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "simulation ok" && exit 0 \
  || { echo "simulation failed"; exit 1; }

//--- test/tb_fetch_unit.sv
`timescale 1ns/100ps

module tb_fetch_unit
  import fetch_pkg::*;
();

  localparam int    REQ_MAX     = 4;
  localparam int    FIFO_AWIDTH = 3;
  localparam word_t START_ADDR  = 32'h0000_1000;
  localparam int    TIMEOUT     = 2000;
  localparam int    SETTLE      = 30;
  localparam int    N_ROWS      = 6;

  typedef struct {
    logic  redirect;
    word_t target;
    int    dec_stall;   // percent
    int    rom_stall;   // percent
    int    count;
  } row_t;

  logic  clk_i, rst_i, cyc_o, stb_o, bus_stall_i, ack_i;
  logic  pc_set_i, halt_i, stall_i, ir_valid_o;
  word_t adr_o, dat_i, pc_in_i, pc_o;
  insn_t ir_o;

  row_t   rows [N_ROWS];
  integer seed = 32'h57a2_f20b;
  int     rom_stall_pct;
  word_t  exp_pc;
  int     taken, checks, errors, tests;
  logic   timed_out;

  fetch_unit #(
    .REQ_MAX     (REQ_MAX),
    .START_ADDR  (START_ADDR),
    .FIFO_AWIDTH (FIFO_AWIDTH)
  ) i_fetch_unit (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_o       (cyc_o),
    .stb_o       (stb_o),
    .adr_o       (adr_o),
    .bus_stall_i (bus_stall_i),
    .ack_i       (ack_i),
    .dat_i       (dat_i),
    .pc_set_i    (pc_set_i),
    .pc_in_i     (pc_in_i),
    .halt_i      (halt_i),
    .stall_i     (stall_i),
    .ir_o        (ir_o),
    .pc_o        (pc_o),
    .ir_valid_o  (ir_valid_o)
  );

  wb_rom_model #(
    .SEED (32'h57a2_f20b)
  ) i_rom_model (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_o),
    .stb_i       (stb_o),
    .adr_i       (adr_o),
    .stall_pct_i (rom_stall_pct),
    .stall_o     (bus_stall_i),
    .ack_o       (ack_i),
    .dat_o       (dat_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic fill_rows;
    rows[0] = '{1'b0, 32'h0000_0000, 0, 0, 16};   // straight run from reset
    rows[1] = '{1'b0, 32'h0000_0000, 30, 30, 40};
    rows[2] = '{1'b1, 32'h0000_200c, 20, 0, 20};  // lands on a long insn
    rows[3] = '{1'b1, 32'h0000_3018, 40, 50, 30};
    rows[4] = '{1'b0, 32'h0000_0000, 90, 10, 30}; // fifo fills under decode stall
    rows[5] = '{1'b1, 32'h0000_0ff0, 0, 60, 24};
  endtask

  function automatic word_t expected_word(input word_t adr);
    word_t w;
    w = adr;
    if (adr[4:2] == 3'd3)
      w[0] = 1'b1;
    return w;
  endfunction

  function automatic logic stall_roll(input int pct);
    return int'($unsigned($random(seed)) % 32'd100) < pct;
  endfunction

  task automatic compare_insn(input string name, input insn_t got, input insn_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_pc(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // outputs quiet in reset, first request one cycle after release
  task automatic check_reset_release;
    int errs_before;
    errs_before = errors;
    compare_bit("cyc_o", cyc_o, 1'b0);
    compare_bit("stb_o", stb_o, 1'b0);
    compare_bit("ir_valid_o", ir_valid_o, 1'b0);
    rst_i = 1'b0;
    @(negedge clk_i);
    compare_bit("stb_o", stb_o, 1'b1);
    compare_pc("adr_o", adr_o, START_ADDR);
    tests++;
    $display("test reset: %0d errors", errors - errs_before);
  endtask

  task automatic check_next_insn;
    insn_t exp_ir;
    logic  is_long;
    is_long = (exp_pc[4:2] == 3'd3);
    if (is_long)
      exp_ir = {expected_word(exp_pc + 32'd4), expected_word(exp_pc)};
    else
      exp_ir = {32'h0000_0000, expected_word(exp_pc)};
    compare_pc("pc_o", pc_o, exp_pc);
    compare_insn("ir_o", ir_o, exp_ir);
    exp_pc = exp_pc + (is_long ? 32'd8 : 32'd4);
    taken++;
  endtask

  // called just after a falling edge, decode takes the insn on the next rise
  task automatic sample_and_drive(input int pct);
    stall_i = stall_roll(pct);
    if (ir_valid_o && !stall_i)
      check_next_insn();
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Error at %0t ns: timed out, %s", $time, what);
  endtask

  task automatic run_row(input int idx);
    int errs_before;
    int cycles;
    errs_before = errors;
    rom_stall_pct = rows[idx].rom_stall;
    if (rows[idx].redirect)
    begin
      cycles = 0;
      @(negedge clk_i);
      while (!(stb_o && ack_i) && cycles < TIMEOUT)
      begin
        sample_and_drive(rows[idx].dec_stall);
        @(negedge clk_i);
        cycles++;
      end
      if (!(stb_o && ack_i))
      begin
        report_timeout("no burst in progress to redirect");
        return;
      end
      pc_set_i = 1'b1;  // insn on the output now is flushed
      pc_in_i  = rows[idx].target;
      stall_i  = 1'b0;
      exp_pc   = rows[idx].target;
    end
    taken  = 0;
    cycles = 0;
    while (taken < rows[idx].count && cycles < TIMEOUT)
    begin
      @(negedge clk_i);
      pc_set_i = 1'b0;
      sample_and_drive(rows[idx].dec_stall);
      cycles++;
    end
    if (taken < rows[idx].count)
      report_timeout($sformatf("test %0d got only %0d instructions", idx, taken));
    tests++;
    $display("test %0d: %0d insns checked, %0d errors", idx, taken, errors - errs_before);
  endtask

  task automatic run_halt;
    int   errs_before;
    int   cycles;
    int   low_run;
    logic restarted;
    errs_before   = errors;
    rom_stall_pct = 20;
    taken         = 0;
    cycles        = 0;
    low_run       = 0;
    restarted     = 1'b0;
    @(negedge clk_i);
    halt_i = 1'b1;  // held until the end of the run
    sample_and_drive(0);
    while (low_run < SETTLE && cycles < TIMEOUT)
    begin
      @(negedge clk_i);
      sample_and_drive(0);
      low_run = cyc_o ? 0 : low_run + 1;
      cycles++;
    end
    if (low_run < SETTLE)
    begin
      report_timeout("cyc_o did not stay low after halt");
      return;
    end
    repeat (SETTLE)
    begin
      @(negedge clk_i);
      sample_and_drive(0);
      if (cyc_o)
        restarted = 1'b1;
    end
    if (restarted)
    begin
      errors++;
      $display("Error at %0t ns: bus cycle started again after halt", $time);
    end
    // a lone long opener may wait for a second word never fetched
    if (exp_pc[4:2] == 3'd3 && adr_o != exp_pc)
      compare_pc("adr_o", adr_o, exp_pc + 32'd4);
    else
      compare_pc("adr_o", adr_o, exp_pc);
    tests++;
    $display("test halt: %0d insns drained, %0d errors", taken, errors - errs_before);
  endtask

  initial
  begin
    rst_i         = 1'b1;
    pc_set_i      = 1'b0;
    pc_in_i       = '0;
    halt_i        = 1'b0;
    stall_i       = 1'b0;
    rom_stall_pct = 0;
    exp_pc        = START_ADDR;
    taken         = 0;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    timed_out     = 1'b0;
    fill_rows();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_reset_release();
    for (int i = 0; i < N_ROWS && !timed_out; i++)
      run_row(i);
    if (!timed_out)
      run_halt();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- test/wb_rom_model.sv
`timescale 1ns/100ps

module wb_rom_model
  import fetch_pkg::*;
#(
  parameter int SEED = 32'h57a2_f20b
)
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  word_t adr_i,
  input  int    stall_pct_i,
  output logic  stall_o,
  output logic  ack_o,
  output word_t dat_o
);

  integer seed = SEED;

  // word is its own address, bit 0 set at word 3 of every 8-word block
  function automatic word_t word_at(input word_t adr);
    word_t w;
    w = adr;
    if (adr[4:2] == 3'd3)
      w[0] = 1'b1;
    return w;
  endfunction

  // stall changes away from the sampling edge
  always @(negedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      stall_o <= 1'b0;
    else
      stall_o <= int'($unsigned($random(seed)) % 32'd100) < stall_pct_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ack_o <= 1'b0;
      dat_o <= '0;
    end
    else
    begin
      ack_o <= cyc_i && stb_i && !stall_o;  // one cycle latency, in order
      dat_o <= word_at(adr_i);
    end
  end

endmodule
